//--- design/smMatrix_consts.svh
`ifndef SM_MATRIX_CONSTS_SVH
`define SM_MATRIX_CONSTS_SVH

// data RAM depth in 32-bit words
`define SM_RAM_WORDS 64

// address map, compared against the upper bits of bAddr
`define SM_RAM_MATCH 2'b00      // bits 15:14, 0x0000 - 0x3fff
`define SM_GPIO_MATCH 12'h7f0   // bits 15:4, 0x7f00 - 0x7f0f
`define SM_PWM_MATCH 12'h7f1    // bits 15:4, 0x7f10 - 0x7f1f
`define SM_ALS_MATCH 12'h7f2    // bits 15:4, 0x7f20 - 0x7f2f

// pin counts
`define SM_GPIO_WIDTH 16
`define SM_PWM_CHANNELS 4

// system clocks per SPI clock half period
`define SM_ALS_SCK_DIV 4

// ram, gpio, als and one line per pwm channel
`define SM_SEL_WIDTH (3 + `SM_PWM_CHANNELS)

`endif

//--- design/smPkg.sv
package smPkg;

    // position of each target in bSel, pwm channel i sits at SEL_PWM0 + i
    typedef enum int {
        SEL_RAM  = 0,
        SEL_GPIO = 1,
        SEL_ALS  = 2,
        SEL_PWM0 = 3
    } selIndex;

    // gpio register word offsets, from bAddr[3:2]
    typedef enum logic [1:0] {
        GPIO_IN  = 2'd0,
        GPIO_OUT = 2'd1
    } gpioReg;

    // light sensor reader states
    typedef enum logic [1:0] {
        ALS_IDLE,
        ALS_SHIFT,
        ALS_GAP
    } alsState;

endpackage

//--- design/smDecoder.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smDecoder (
    input  logic [31:0]               bAddr,
    output logic [`SM_SEL_WIDTH-1:0]  bSel
);
    logic pwmHit;

    assign pwmHit = (bAddr[15:4] == `SM_PWM_MATCH);  // whole pwm block

    always_comb begin
        bSel = '0;  // holes select nothing

        bSel[smPkg::SEL_RAM]  = (bAddr[15:14] == `SM_RAM_MATCH);
        bSel[smPkg::SEL_GPIO] = (bAddr[15:4] == `SM_GPIO_MATCH);
        bSel[smPkg::SEL_ALS]  = (bAddr[15:4] == `SM_ALS_MATCH);

        // channel number from the word offset inside the pwm block
        for (int i = 0; i < `SM_PWM_CHANNELS; i++) begin
            bSel[smPkg::SEL_PWM0 + i] = pwmHit && (bAddr[3:2] == 2'(i));
        end
    end

endmodule

//--- design/smReadMux.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smReadMux (
    input  logic [`SM_SEL_WIDTH-1:0] bSel,
    input  logic [31:0]              ramRData,
    input  logic [31:0]              gpioRData,
    input  logic [31:0]              alsRData,
    input  logic [31:0]              pwmRData [`SM_PWM_CHANNELS],
    output logic [31:0]              bRData
);
    logic [31:0] words [`SM_SEL_WIDTH];  // read word per select line

    always_comb begin
        words[smPkg::SEL_RAM]  = ramRData;
        words[smPkg::SEL_GPIO] = gpioRData;
        words[smPkg::SEL_ALS]  = alsRData;
        for (int i = 0; i < `SM_PWM_CHANNELS; i++) begin
            words[smPkg::SEL_PWM0 + i] = pwmRData[i];
        end
    end

    // scan from the top so the lowest set bit wins
    always_comb begin
        bRData = '0;  // unmapped reads as zero
        for (int i = `SM_SEL_WIDTH - 1; i >= 0; i--) begin
            if (bSel[i]) begin
                bRData = words[i];
            end
        end
    end

endmodule

//--- design/smRam.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smRam (
    input  logic        clk,
    input  logic        sel,
    input  logic [31:0] bAddr,
    input  logic        bWrite,
    input  logic [31:0] bWData,
    output logic [31:0] rData
);
    localparam int addrWidth = $clog2(`SM_RAM_WORDS);

    logic [31:0]          mem [`SM_RAM_WORDS];
    logic [addrWidth-1:0] index;

    assign index = bAddr[addrWidth+1:2];  // word address, aliases past the depth

    always_ff @(posedge clk) begin
        if (sel && bWrite) begin
            mem[index] <= bWData;
        end
    end

    assign rData = mem[index];  // combinational read

endmodule

//--- design/smGpio.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smGpio (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sel,
    input  logic [31:0]                bAddr,
    input  logic                       bWrite,
    input  logic [31:0]                bWData,
    input  logic [`SM_GPIO_WIDTH-1:0]  gpioInput,
    output logic [31:0]                rData,
    output logic [`SM_GPIO_WIDTH-1:0]  gpioOutput
);
    logic [`SM_GPIO_WIDTH-1:0] syncMeta;  // first stage, may go metastable
    logic [`SM_GPIO_WIDTH-1:0] syncIn;

    always_ff @(posedge clk) begin
        if (rst) begin
            syncMeta   <= '0;
            syncIn     <= '0;
            gpioOutput <= '0;
        end else begin
            syncMeta <= gpioInput;
            syncIn   <= syncMeta;
            if (sel && bWrite && bAddr[3:2] == smPkg::GPIO_OUT) begin
                gpioOutput <= bWData[`SM_GPIO_WIDTH-1:0];
            end
        end
    end

    always_comb begin
        case (bAddr[3:2])
            smPkg::GPIO_IN:  rData = 32'(syncIn);
            smPkg::GPIO_OUT: rData = 32'(gpioOutput);
            default:         rData = '0;  // spare offsets
        endcase
    end

endmodule

//--- design/smPwm.sv
`timescale 1ns/1ps

module smPwm (
    input  logic        clk,
    input  logic        rst,
    input  logic        sel,
    input  logic        bWrite,
    input  logic [31:0] bWData,
    output logic [31:0] rData,
    output logic        pwmOutput
);
    logic [7:0] duty;
    logic [7:0] counter;

    // counter wraps 255 to 0, so one period is 256 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            counter <= '0;
        end else begin
            counter <= counter + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            duty <= '0;
        end else if (sel && bWrite) begin
            duty <= bWData[7:0];  // low byte only
        end
    end

    // high for exactly duty counts of every period
    assign pwmOutput = (counter < duty);

    assign rData = {24'b0, duty};

endmodule

//--- design/smAls.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smAls (
    input  logic        clk,
    input  logic        rst,
    output logic        cs,
    output logic        sck,
    input  logic        sdo,
    output logic [31:0] value
);
    localparam int divWidth = $clog2(`SM_ALS_SCK_DIV + 1);
    localparam logic [divWidth-1:0] divLast = divWidth'(`SM_ALS_SCK_DIV - 1);

    smPkg::alsState      state;
    logic [divWidth-1:0] divCnt;
    logic                halfTick;  // end of an sck half period
    logic [3:0]          bitCnt;
    logic [15:0]         shiftReg;  // whole frame, msb first
    logic [7:0]          sample;

    assign halfTick = (divCnt == divLast);

    // rising sck edge samples sdo
    always_ff @(posedge clk) begin
        if (state == smPkg::ALS_SHIFT && halfTick && !sck) begin
            shiftReg <= {shiftReg[14:0], sdo};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= smPkg::ALS_IDLE;
            cs     <= 1'b1;
            sck    <= 1'b0;
            divCnt <= '0;
            bitCnt <= '0;
            sample <= '0;
        end else begin
            divCnt <= halfTick ? '0 : divCnt + 1'b1;
            case (state)
                smPkg::ALS_IDLE: begin
                    cs     <= 1'b0;  // start a frame
                    divCnt <= '0;
                    bitCnt <= '0;
                    state  <= smPkg::ALS_SHIFT;
                end
                smPkg::ALS_SHIFT: begin
                    if (halfTick) begin
                        sck <= ~sck;
                        if (sck) begin
                            bitCnt <= bitCnt + 4'd1;
                            if (bitCnt == 4'd15) begin
                                // 16th falling edge, frame complete
                                cs     <= 1'b1;
                                sample <= shiftReg[12:5];
                                state  <= smPkg::ALS_GAP;
                            end
                        end
                    end
                end
                smPkg::ALS_GAP: begin
                    if (halfTick) begin
                        state <= smPkg::ALS_IDLE;
                    end
                end
                default: state <= smPkg::ALS_IDLE;
            endcase
        end
    end

    assign value = {24'b0, sample};

endmodule

//--- design/smMatrix.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smMatrix (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [31:0]                   bAddr,      // bus address
    input  logic                          bWrite,     // bus write enable
    input  logic [31:0]                   bWData,     // bus write data
    output logic [31:0]                   bRData,     // bus read data
    input  logic [`SM_GPIO_WIDTH-1:0]     gpioInput,
    output logic [`SM_GPIO_WIDTH-1:0]     gpioOutput,
    output logic [`SM_PWM_CHANNELS-1:0]   pwmOutput,
    output logic                          alsCS,      // sensor chip select
    output logic                          alsSCK,     // sensor spi clock
    input  logic                          alsSDO      // sensor spi data
);
    logic [`SM_SEL_WIDTH-1:0] bSel;
    logic [31:0] ramRData;
    logic [31:0] gpioRData;
    logic [31:0] alsRData;
    logic [31:0] pwmRData [`SM_PWM_CHANNELS];

    smDecoder u_decoder (.bAddr(bAddr), .bSel(bSel));

    smRam u_ram (
        .clk(clk), .sel(bSel[smPkg::SEL_RAM]), .bAddr(bAddr),
        .bWrite(bWrite), .bWData(bWData), .rData(ramRData)
    );

    smGpio u_gpio (
        .clk(clk), .rst(rst), .sel(bSel[smPkg::SEL_GPIO]), .bAddr(bAddr),
        .bWrite(bWrite), .bWData(bWData), .gpioInput(gpioInput),
        .rData(gpioRData), .gpioOutput(gpioOutput)
    );

    // one channel per select line, channel decode lives in smDecoder
    for (genvar i = 0; i < `SM_PWM_CHANNELS; i++) begin : gPwm
        smPwm u_pwm (
            .clk(clk), .rst(rst), .sel(bSel[smPkg::SEL_PWM0 + i]),
            .bWrite(bWrite), .bWData(bWData),
            .rData(pwmRData[i]), .pwmOutput(pwmOutput[i])
        );
    end

    smAls u_als (
        .clk(clk), .rst(rst), .cs(alsCS), .sck(alsSCK),
        .sdo(alsSDO), .value(alsRData)
    );

    smReadMux u_readMux (
        .bSel(bSel), .ramRData(ramRData), .gpioRData(gpioRData),
        .alsRData(alsRData), .pwmRData(pwmRData), .bRData(bRData)
    );

endmodule

//--- verif/smMatrix_asserts.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smMatrixAsserts (
    input logic                       clk,
    input logic                       rst,
    input logic [31:0]                bAddr,
    input logic                       bWrite,
    input logic [`SM_SEL_WIDTH-1:0]   bSel,
    input logic                       alsCS,
    input logic [`SM_GPIO_WIDTH-1:0]  gpioOutput
);
    logic gpioWrite;  // bus write to GPIO_OUT

    assign gpioWrite = bWrite && bSel[smPkg::SEL_GPIO] && (bAddr[3:2] == smPkg::GPIO_OUT);

    selOneHot: assert property (@(posedge clk) $onehot0(bSel))
        else $error("more than one target selected, bSel = %b", bSel);

    // first cycle out of reset, no frame started yet
    csAfterReset: assert property (@(posedge clk) $fell(rst) |-> alsCS)
        else $error("alsCS is low in the first cycle after reset");

    gpioOnlyOnWrite: assert property (@(posedge clk) disable iff (rst)
        !$stable(gpioOutput) |-> $past(gpioWrite))
        else $error("gpioOutput changed without a GPIO_OUT write");

endmodule

bind smMatrix smMatrixAsserts u_asserts (
    .clk(clk), .rst(rst), .bAddr(bAddr), .bWrite(bWrite), .bSel(bSel),
    .alsCS(alsCS), .gpioOutput(gpioOutput)
);

//--- verif/smMatrixTb.sv
`timescale 1ns/1ps
`include "smMatrix_consts.svh"

module smMatrixTb;
    localparam int halfPeriod = 5;
    localparam int testCount = 6;
    localparam int watchdogCycles = testCount * 2000 + 10000;
    localparam logic [31:0] gpioInAddr = 32'h7f00;
    localparam logic [31:0] gpioOutAddr = 32'h7f04;
    localparam logic [31:0] pwmBase = 32'h7f10;
    localparam logic [31:0] alsAddr = 32'h7f20;

    logic clk;
    logic rst;
    logic [31:0] bAddr;
    logic bWrite;
    logic [31:0] bWData;
    logic [31:0] bRData;
    logic [`SM_GPIO_WIDTH-1:0] gpioInput;
    logic [`SM_GPIO_WIDTH-1:0] gpioOutput;
    logic [`SM_PWM_CHANNELS-1:0] pwmOutput;
    logic alsCS;
    logic alsSCK;
    logic alsSDO;

    // reference copies of the target registers
    logic [31:0] ramModel [`SM_RAM_WORDS];
    logic [`SM_GPIO_WIDTH-1:0] gpioOutModel;
    logic [`SM_GPIO_WIDTH-1:0] gpioInModel;
    logic [7:0] dutyModel [`SM_PWM_CHANNELS];
    logic [7:0] alsModel = 8'h00;  // last completed sensor frame

    logic [31:0] lfsrState = 32'hfe4c_85bd;

    // reads waiting for the compare process
    string nameQ[$];
    logic [31:0] expQ[$];
    logic [31:0] actQ[$];
    event readDone;

    // sensor model state
    logic prevCs = 1'b1;
    logic prevSck = 1'b0;
    logic [15:0] frame = 16'h0000;
    logic [7:0] sentSample = 8'h00;

    smMatrix u_smMatrix (
        .clk(clk), .rst(rst), .bAddr(bAddr), .bWrite(bWrite), .bWData(bWData),
        .bRData(bRData), .gpioInput(gpioInput), .gpioOutput(gpioOutput),
        .pwmOutput(pwmOutput), .alsCS(alsCS), .alsSCK(alsSCK), .alsSDO(alsSDO)
    );

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            r = {r[30:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic int ramIndex(input logic [31:0] addr);
        return int'((addr >> 2) % `SM_RAM_WORDS);  // word address wraps at the depth
    endfunction

    function automatic logic [31:0] expectedRead(input logic [31:0] addr);
        logic [31:0] result;
        result = '0;
        if (addr[15:14] == `SM_RAM_MATCH) begin
            result = ramModel[ramIndex(addr)];
        end else if (addr[15:4] == `SM_GPIO_MATCH) begin
            if (addr[3:2] == 2'd0) result = 32'(gpioInModel);
            else if (addr[3:2] == 2'd1) result = 32'(gpioOutModel);
        end else if (addr[15:4] == `SM_PWM_MATCH) begin
            result = 32'(dutyModel[addr[3:2]]);
        end else if (addr[15:4] == `SM_ALS_MATCH) begin
            result = 32'(alsModel);
        end
        return result;
    endfunction

    task automatic modelWrite(input logic [31:0] addr, input logic [31:0] data);
        if (addr[15:14] == `SM_RAM_MATCH) begin
            ramModel[ramIndex(addr)] = data;
        end else if (addr[15:4] == `SM_GPIO_MATCH && addr[3:2] == 2'd1) begin
            gpioOutModel = data[`SM_GPIO_WIDTH-1:0];
        end else if (addr[15:4] == `SM_PWM_MATCH) begin
            dutyModel[addr[3:2]] = data[7:0];
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic busWrite(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        bAddr = addr;
        bWData = data;
        bWrite = 1'b1;
        modelWrite(addr, data);
        @(negedge clk);
        bWrite = 1'b0;
    endtask

    task automatic busRead(input string name, input logic [31:0] addr);
        @(negedge clk);
        bAddr = addr;
        bWrite = 1'b0;
        #(halfPeriod - 1);  // just before the rising edge
        nameQ.push_back(name);
        expQ.push_back(expectedRead(addr));
        actQ.push_back(bRData);
        -> readDone;
    endtask

    task automatic resetTest();
        check("reset gpioOutput", 32'h0, 32'(gpioOutput));
        check("reset pwmOutput", 32'h0, 32'(pwmOutput));
        check("reset alsCS", 32'h1, 32'(alsCS));
        check("reset alsSCK", 32'h0, 32'(alsSCK));
        busRead("reset gpio out", gpioOutAddr);
        for (int ch = 0; ch < `SM_PWM_CHANNELS; ch++) begin
            busRead("reset duty", pwmBase + 32'(4 * ch));
        end
    endtask

    task automatic ramTest();
        logic [31:0] addrs[$];
        logic [31:0] addr;
        repeat (16) begin
            addr = randBits(12) << 2;  // anywhere in 0x0000 - 0x3ffc
            addrs.push_back(addr);
            busWrite(addr, randBits(32));
        end
        foreach (addrs[i]) busRead("ram readback", addrs[i]);
        busWrite(32'h0010, randBits(32));
        busRead("ram alias up", 32'h0010 + 32'(`SM_RAM_WORDS * 4));
        busWrite(32'h0024 + 32'(`SM_RAM_WORDS * 8), randBits(32));
        busRead("ram alias down", 32'h0024);
    endtask

    task automatic gpioTest();
        logic [`SM_GPIO_WIDTH-1:0] pins;
        busWrite(gpioOutAddr, randBits(32));
        check("gpio output pins", 32'(gpioOutModel), 32'(gpioOutput));
        busRead("gpio out readback", gpioOutAddr);
        pins = `SM_GPIO_WIDTH'(randBits(`SM_GPIO_WIDTH));
        @(negedge clk);
        gpioInput = pins;
        gpioInModel = pins;
        repeat (3) @(posedge clk);  // two sync flops plus margin
        busRead("gpio in readback", gpioInAddr);
    endtask

    task automatic pwmTest();
        int count;
        logic [7:0] duty;
        for (int ch = 0; ch < `SM_PWM_CHANNELS; ch++) begin
            duty = 8'(randBits(8));
            busWrite(pwmBase + 32'(4 * ch), {24'(randBits(24)), duty});
            busRead("pwm duty readback", pwmBase + 32'(4 * ch));
            count = 0;
            repeat (256) begin
                @(negedge clk);
                if (pwmOutput[ch]) count++;
            end
            check("pwm high count", 32'(duty), 32'(count));
        end
        for (int ch = 0; ch < `SM_PWM_CHANNELS; ch++) begin
            busRead("pwm duty kept", pwmBase + 32'(4 * ch));
        end
    endtask

    task automatic alsTest();
        repeat (2) @(posedge alsCS);
        busRead("als value", alsAddr);
    endtask

    task automatic unmappedTest();
        busWrite(32'h0000, randBits(32));
        busRead("hole 0x7f30", 32'h7f30);
        busRead("hole 0x8000", 32'h8000);
        busWrite(32'h7f30, randBits(32));
        busWrite(32'h8000, randBits(32));
        busRead("hole 0x7f30 after write", 32'h7f30);
        busRead("hole 0x8000 after write", 32'h8000);
        busRead("ram after hole write", 32'h0000);
        busRead("gpio after hole write", gpioOutAddr);
        for (int ch = 0; ch < `SM_PWM_CHANNELS; ch++) begin
            busRead("duty after hole write", pwmBase + 32'(4 * ch));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // light sensor sends 3 zeros, the sample and 5 zeros msb first
    always @(negedge clk) begin
        if (prevCs && !alsCS) begin
            sentSample = 8'(randBits(8));
            frame = {3'b000, sentSample, 5'b00000};
            alsSDO = frame[15];
            frame = {frame[14:0], 1'b0};
        end else if (!alsCS && prevSck && !alsSCK) begin
            alsSDO = frame[15];  // next bit after a falling sck
            frame = {frame[14:0], 1'b0};
        end
        if (!prevCs && alsCS) alsModel = sentSample;  // frame done
        prevCs = alsCS;
        prevSck = alsSCK;
    end

    initial begin
        forever begin
            @(readDone);
            while (actQ.size() > 0) begin
                check(nameQ.pop_front(), expQ.pop_front(), actQ.pop_front());
            end
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdogCycles);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        bAddr = '0;
        bWrite = 1'b0;
        bWData = '0;
        gpioInput = '0;
        alsSDO = 1'b0;
        rst = 1'b1;
        gpioOutModel = '0;
        gpioInModel = '0;
        for (int ch = 0; ch < `SM_PWM_CHANNELS; ch++) dutyModel[ch] = 8'h00;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        resetTest();
        ramTest();
        gpioTest();
        pwmTest();
        alsTest();
        unmappedTest();
        @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- smMatrix.f
+incdir+design
design/smPkg.sv
design/smDecoder.sv
design/smReadMux.sv
design/smRam.sv
design/smGpio.sv
design/smPwm.sv
design/smAls.sv
design/smMatrix.sv
verif/smMatrix_asserts.sv
verif/smMatrixTb.sv

//--- run.sh
#!/bin/sh
# compile and run the smMatrix testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module smMatrixTb \
        -f smMatrix.f -o smMatrixSim; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/smMatrixSim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi

echo "simulation output has no passing result"
exit 1
